//--- Bender.yml
package:
  name: tile_loader

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tile_pkgs.sv
      - verilog/mem_rd_if.sv
      - verilog/nest3_counter.sv
      - verilog/mem_arbiter.sv
      - verilog/in_fm_filter.sv
      - verilog/in_fm_loader.sv
      - verilog/weight_loader.sv
      - verilog/tile_fifo.sv
      - verilog/tile_loader_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_clock_gen.sv
      - dv/tile_loader_tb.sv

//--- compile.f
+incdir+verilog
verilog/tile_pkgs.sv
verilog/mem_rd_if.sv
verilog/nest3_counter.sv
verilog/mem_arbiter.sv
verilog/in_fm_filter.sv
verilog/in_fm_loader.sv
verilog/weight_loader.sv
verilog/tile_fifo.sv
verilog/tile_loader_top.sv
dv/tb_clock_gen.sv
dv/tile_loader_tb.sv

//--- dv/tb_clock_gen.sv
/*
 * Free-running testbench clock, 8 ns period.
 */

`default_nettype none

module tb_clock_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #4 clk = ~clk;   // Half period.

endmodule

`default_nettype wire

//--- dv/tile_loader_tb.sv
/*
 * Testbench for the tile input stage: external memory model, FIFO consumer,
 * reference word sequences and checking assertions.
 */

`default_nettype none

`include "loader_defs.svh"

module tile_loader_tb import tile_geom_pkg::*, mem_port_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TILE_WORDS = `TILE_TM * `TILE_TR * `TILE_TC;

    logic         clk;
    logic         rst;
    logic         start;
    coord_t       tile_base_m, tile_base_row, tile_base_col;
    mem_addr_t    weight_base;
    logic         busy;
    logic         mem_req;
    mem_addr_t    mem_addr;
    logic         mem_gnt = 1'b0;
    logic         mem_rvalid = 1'b0;
    mem_data_t    mem_rdata = '0;
    fm_word_t     fm_data;
    logic         fm_empty;
    logic         fm_pop = 1'b0;
    weight_word_t w_data;
    logic         w_empty;
    logic         w_pop = 1'b0;

    logic [31:0]  rng_state = 32'h7e99_eaa2;
    logic         gnt_random = 1'b0;
    int           pop_mode = 1;         // 0 hold, 1 every cycle, 2 sparse.
    mem_addr_t    prev_addr = '0;
    int           rd_accepted = 0;
    int           rd_returned = 0;
    int           rd_expected = 0;      // Running total over all starts.

    fm_word_t     fm_ref [512];         // Expected words, in pop order.
    weight_word_t w_ref [512];
    int           fm_ref_len = 0;
    int           w_ref_len = 0;
    int           fm_rd_idx = 0;
    int           w_rd_idx = 0;
    fm_word_t     fm_exp;
    weight_word_t w_exp;
    int           errors = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           err0;

    assign fm_exp = fm_ref[fm_rd_idx];
    assign w_exp  = w_ref[w_rd_idx];

    tb_clock_gen clk_gen (.clk(clk));

    tile_loader_top uut (
        .clk(clk), .rst(rst), .start(start),
        .tile_base_m(tile_base_m), .tile_base_row(tile_base_row),
        .tile_base_col(tile_base_col), .weight_base(weight_base), .busy(busy),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_gnt(mem_gnt),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
        .fm_data(fm_data), .fm_empty(fm_empty), .fm_pop(fm_pop),
        .w_data(w_data), .w_empty(w_empty), .w_pop(w_pop)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Contents of the external memory.
    function automatic mem_data_t mem_word(input mem_addr_t a);
        return 32'(a) * 32'h9e37_79b9 + 32'(a);
    endfunction

    // Memory port and FIFO consumer, one random draw per cycle.
    always @(posedge clk) begin
        if (rst) begin
            mem_gnt    <= 1'b0;
            mem_rvalid <= 1'b0;
            fm_pop     <= 1'b0;
            w_pop      <= 1'b0;
        end else begin
            rng_state  <= next_random(rng_state);
            mem_rvalid <= mem_req && mem_gnt;   // One cycle after acceptance.
            if (mem_req && mem_gnt) begin
                mem_rdata   <= mem_word(mem_addr);
                rd_accepted <= rd_accepted + 1;
            end
            if (mem_rvalid) rd_returned <= rd_returned + 1;
            mem_gnt <= gnt_random ? rng_state[0] : 1'b1;
            case (pop_mode)
                0: begin
                    fm_pop <= 1'b0;
                    w_pop  <= 1'b0;
                end
                1: begin
                    fm_pop <= 1'b1;
                    w_pop  <= 1'b1;
                end
                default: begin
                    fm_pop <= (rng_state[7:5] == 3'd0);
                    w_pop  <= (rng_state[10:8] == 3'd0);
                end
            endcase
            if (fm_pop && !fm_empty) fm_rd_idx <= fm_rd_idx + 1;
            if (w_pop && !w_empty) w_rd_idx <= w_rd_idx + 1;
        end
        prev_addr <= mem_addr;
    end

    reset_outputs: assert property (@(posedge clk)
            rst |-> (!busy && !mem_req && fm_empty && w_empty))
        else begin
            errors++;
            $display("error: reset outputs busy=%h mem_req=%h fm_empty=%h w_empty=%h",
                     $sampled(busy), $sampled(mem_req), $sampled(fm_empty), $sampled(w_empty));
        end

    fm_word_check: assert property (@(posedge clk) disable iff (rst)
            (fm_pop && !fm_empty && fm_rd_idx < fm_ref_len) |-> (fm_data == fm_exp))
        else begin
            errors++;
            $display("error: fm_data = %h, expected %h (word %0d)",
                     $sampled(fm_data), $sampled(fm_exp), $sampled(fm_rd_idx));
        end

    fm_extra_check: assert property (@(posedge clk) disable iff (rst)
            (fm_pop && !fm_empty) |-> (fm_rd_idx < fm_ref_len))
        else begin
            errors++;
            $display("a feature-map word arrived that no tile accounts for");
        end

    w_word_check: assert property (@(posedge clk) disable iff (rst)
            (w_pop && !w_empty && w_rd_idx < w_ref_len) |-> (w_data == w_exp))
        else begin
            errors++;
            $display("error: w_data = %h, expected %h (word %0d)",
                     $sampled(w_data), $sampled(w_exp), $sampled(w_rd_idx));
        end

    w_extra_check: assert property (@(posedge clk) disable iff (rst)
            (w_pop && !w_empty) |-> (w_rd_idx < w_ref_len))
        else begin
            errors++;
            $display("a weight arrived that no tile accounts for");
        end

    // Back-pressure must not move the address.
    addr_hold_check: assert property (@(posedge clk) disable iff (rst)
            (mem_req && !mem_gnt) |=> (!mem_req || mem_addr == prev_addr))
        else begin
            errors++;
            $display("error: mem_addr = %h, expected %h", $sampled(mem_addr), $sampled(prev_addr));
        end

    busy_rise_check: assert property (@(posedge clk) disable iff (rst)
            (start && !busy) |=> busy)
        else begin
            errors++;
            $display("busy did not rise on the cycle after start");
        end

    busy_fall_check: assert property (@(posedge clk) disable iff (rst)
            $fell(busy) |-> (rd_accepted == rd_expected && rd_returned == rd_expected))
        else begin
            errors++;
            $display("busy fell after %0d accepted and %0d returned reads, expected %0d",
                     $sampled(rd_accepted), $sampled(rd_returned), $sampled(rd_expected));
        end

    idle_check: assert property (@(posedge clk) disable iff (rst) !busy |-> !mem_req)
        else begin
            errors++;
            $display("a memory read was requested while idle");
        end

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Test failures found");
        $finish;
    endtask

    // Appends the words that one start must deliver.
    task automatic add_expected(input coord_t bm, input coord_t br, input coord_t bc,
                                input mem_addr_t wb);
        int        gm, gr, gc;
        mem_addr_t a;
        mem_data_t d;
        for (int m = 0; m < `TILE_TM; m++) begin
            for (int r = 0; r < `TILE_TR; r++) begin
                for (int c = 0; c < `TILE_TC; c++) begin
                    gm = int'(bm) + m;
                    gr = int'(br) + r;
                    gc = int'(bc) + c;
                    a  = mem_addr_t'((gm * `FM_R + gr) * `FM_C + gc);
                    if (gm >= `FM_M || gr >= `FM_R || gc >= `FM_C) fm_ref[fm_ref_len] = '0;
                    else fm_ref[fm_ref_len] = mem_word(a);
                    fm_ref_len++;
                end
            end
        end
        for (int i = 0; i < `WT_WORDS; i++) begin
            d = mem_word(wb + mem_addr_t'(i));
            w_ref[w_ref_len] = d[`WT_DW-1:0];
            w_ref_len++;
        end
        rd_expected += TILE_WORDS + `WT_WORDS;
    endtask

    task automatic set_traffic(input logic rand_gnt, input int pmode);
        @(posedge clk);
        gnt_random <= rand_gnt;
        pop_mode   <= pmode;
    endtask

    task automatic pulse_start(input coord_t bm, input coord_t br, input coord_t bc,
                               input mem_addr_t wb);
        @(posedge clk);
        start         <= 1'b1;
        tile_base_m   <= bm;
        tile_base_row <= br;
        tile_base_col <= bc;
        weight_base   <= wb;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            if (n == limit) abort_on_timeout("busy never fell");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (fm_rd_idx != fm_ref_len || w_rd_idx != w_ref_len) begin
            if (n == limit) abort_on_timeout("the FIFOs never delivered every expected word");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic check_leftovers();
        assert (fm_empty && w_empty && rd_accepted == rd_expected)
        else begin
            errors++;
            $display(
                "words left over or wrong read count: fm_empty=%0d w_empty=%0d reads %0d of %0d",
                fm_empty, w_empty, rd_accepted, rd_expected);
        end
    endtask

    task automatic run_tiles(input coord_t bm, input coord_t br, input coord_t bc,
                             input mem_addr_t wb);
        add_expected(bm, br, bc, wb);
        pulse_start(bm, br, bc, wb);
        wait_idle(5000);
        wait_drained(5000);
        check_leftovers();
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", num, name, errors - err_before);
        end
    endtask

    initial begin
        rst           = 1'b1;
        start         = 1'b0;
        tile_base_m   = '0;
        tile_base_row = '0;
        tile_base_col = '0;
        weight_base   = '0;
        err0 = errors;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!busy && !mem_req && fm_empty && w_empty)
        else begin
            errors++;
            $display("outputs left their reset values after reset was released");
        end
        report_test(1, "reset state", err0);

        err0 = errors;
        run_tiles(8'd0, 8'd2, 8'd2, 16'h0100);
        report_test(2, "interior tile", err0);

        err0 = errors;
        run_tiles(8'd4, 8'd8, 8'd8, 16'h0200);
        report_test(3, "edge tile", err0);

        err0 = errors;
        set_traffic(1'b1, 1);
        run_tiles(8'd1, 8'd3, 8'd5, 16'hfff0);   // Weight block wraps the address space.
        report_test(4, "weight tile under contention", err0);

        err0 = errors;
        add_expected(8'd2, 8'd6, 8'd0, 16'h1234);
        set_traffic(1'b1, 0);
        pulse_start(8'd2, 8'd6, 8'd0, 16'h1234);
        repeat (300) @(posedge clk);            // Both FIFOs fill and stall.
        set_traffic(1'b1, 2);
        wait_idle(20000);
        wait_drained(20000);
        check_leftovers();
        report_test(5, "back-pressure", err0);

        err0 = errors;
        set_traffic(1'b1, 1);
        add_expected(8'd3, 8'd1, 8'd7, 16'h0808);
        pulse_start(8'd3, 8'd1, 8'd7, 16'h0808);
        for (int n = 0; rd_accepted < rd_expected - 10; n++) begin
            if (n == 2000) abort_on_timeout("the reads of the tile stopped early");
            @(negedge clk);
        end
        // Weights are all in, the feature map still loads.
        pulse_start(8'd0, 8'd0, 8'd0, 16'h4000);
        wait_idle(5000);
        wait_drained(5000);
        check_leftovers();
        report_test(6, "busy rule", err0);

        $display("summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/in_fm_filter.sv
/*
 * Registers returned feature-map words and zeroes elements outside the map.
 */

`default_nettype none

`include "loader_defs.svh"

module in_fm_filter import tile_geom_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     fifo_push_tmp,
    input  fm_word_t data_to_fifo_tmp,
    output logic     fifo_push,
    output fm_word_t data_to_fifo,
    input  coord_t   tile_base_m,
    input  coord_t   tile_base_row,
    input  coord_t   tile_base_col
);

    fm_word_t data_q;
    coord_t   tc, tr, tm;
    logic     done;
    logic     is_legal;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) fifo_push <= 1'b0;
        else fifo_push <= fifo_push_tmp;
    end

    always_ff @(posedge clk) begin
        if (fifo_push_tmp) data_q <= data_to_fifo_tmp;
    end

    // Position of the word now leaving, column fastest.
    nest3_counter #(
        .n0_max(`TILE_TC),
        .n1_max(`TILE_TR),
        .n2_max(`TILE_TM)
    ) elem_cnt (
        .clk  (clk),
        .rst  (rst),
        .ena  (fifo_push),
        .clean(done),       // Restart for the next tile.
        .cnt0 (tc),
        .cnt1 (tr),
        .cnt2 (tm),
        .done (done)
    );

    // One spare bit keeps base plus offset from wrapping.
    assign is_legal = ({1'b0, tile_base_m} + {1'b0, tm} < (`CW+1)'(`FM_M)) &&
                      ({1'b0, tile_base_row} + {1'b0, tr} < (`CW+1)'(`FM_R)) &&
                      ({1'b0, tile_base_col} + {1'b0, tc} < (`CW+1)'(`FM_C));

    assign data_to_fifo = is_legal ? data_q : '0;

endmodule

`default_nettype wire

//--- verilog/in_fm_loader.sv
/*
 * Input feature-map tile loader. Walks the tile, issues the reads
 * and passes the responses through the range filter.
 */

`default_nettype none

`include "loader_defs.svh"

module in_fm_loader import tile_geom_pkg::*, mem_port_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  coord_t     tile_base_m,
    input  coord_t     tile_base_row,
    input  coord_t     tile_base_col,
    mem_rd_if.requester mem,
    input  logic [3:0] free_slots,
    output logic       push,
    output fm_word_t   push_data,
    output logic       busy
);

    localparam int TILE_WORDS = `TILE_TM * `TILE_TR * `TILE_TC;

    coord_t     base_m_q, base_row_q, base_col_q;
    coord_t     tc, tr, tm;
    logic       go;
    logic       walk_done;
    logic       issued_all;
    logic [1:0] inflight;       // Accepted but not yet pushed.
    logic [6:0] push_cnt;
    mem_addr_t  g_m, g_r, g_c;

    assign go = start && !busy;

    always_ff @(posedge clk) begin
        if (go) begin
            base_m_q   <= tile_base_m;
            base_row_q <= tile_base_row;
            base_col_q <= tile_base_col;
        end
    end

    nest3_counter #(
        .n0_max(`TILE_TC),
        .n1_max(`TILE_TR),
        .n2_max(`TILE_TM)
    ) addr_walk (
        .clk  (clk),
        .rst  (rst),
        .ena  (mem.gnt),
        .clean(go),
        .cnt0 (tc),
        .cnt1 (tr),
        .cnt2 (tm),
        .done (walk_done)
    );

    // Global coordinates and flat word address.
    assign g_m = mem_addr_t'(base_m_q) + mem_addr_t'(tm);
    assign g_r = mem_addr_t'(base_row_q) + mem_addr_t'(tr);
    assign g_c = mem_addr_t'(base_col_q) + mem_addr_t'(tc);
    assign mem.addr = (g_m * mem_addr_t'(`FM_R) + g_r) * mem_addr_t'(`FM_C) + g_c;

    // Room is reserved for every word still on its way.
    assign mem.req = busy && !issued_all && (inflight < 2'd2) &&
                     (free_slots > {2'b00, inflight});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            issued_all <= 1'b0;
            inflight   <= '0;
            push_cnt   <= '0;
        end else begin
            inflight <= inflight + {1'b0, mem.gnt} - {1'b0, push};
            if (go) begin
                busy       <= 1'b1;
                issued_all <= 1'b0;
                push_cnt   <= '0;
            end else begin
                if (walk_done) issued_all <= 1'b1;
                if (push) begin
                    push_cnt <= push_cnt + 1'b1;
                    if (push_cnt == 7'(TILE_WORDS - 1)) busy <= 1'b0;  // Last word in.
                end
            end
        end
    end

    in_fm_filter filter (
        .clk             (clk),
        .rst             (rst),
        .fifo_push_tmp   (mem.rvalid),
        .data_to_fifo_tmp(mem.rdata),
        .fifo_push       (push),
        .data_to_fifo    (push_data),
        .tile_base_m     (base_m_q),
        .tile_base_row   (base_row_q),
        .tile_base_col   (base_col_q)
    );

endmodule

`default_nettype wire

//--- verilog/loader_defs.svh
/*
 * Tile, feature-map and bus size macros for the tile input stage.
 */

`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// Input tile shape.
`define TILE_TM 4
`define TILE_TR 4
`define TILE_TC 4

// Whole feature map.
`define FM_M 6
`define FM_R 10
`define FM_C 10

`define WT_WORDS 36     // Words per weight tile.
`define MEM_AW 16
`define MEM_DW 32
`define WT_DW 16
`define CW 8            // Coordinate width.
`define FIFO_DEPTH 8

`endif

//--- verilog/mem_arbiter.sv
/*
 * Round-robin arbiter of two read requesters onto one memory port.
 * Records the owner of each accepted read and routes its response back.
 */

`default_nettype none

module mem_arbiter import mem_port_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    mem_rd_if.arbiter fm_port,
    mem_rd_if.arbiter wt_port,
    output logic      mem_req,
    input  logic      mem_gnt,
    output mem_addr_t mem_addr,
    input  logic      mem_rvalid,
    input  mem_data_t mem_rdata
);

    req_sel_t prio;         // Preferred requester on a tie.
    req_sel_t win;
    req_sel_t owner;        // Requester of the read now returning.
    logic     stall_q;
    req_sel_t stall_sel;
    logic     accept;

    // A stalled request keeps its slot so the address stays put.
    always_comb begin
        if (stall_q) win = stall_sel;
        else if (fm_port.req && wt_port.req) win = prio;
        else if (wt_port.req) win = SEL_WT;
        else win = SEL_FM;
    end

    assign mem_req  = fm_port.req || wt_port.req;
    assign mem_addr = (win == SEL_WT) ? wt_port.addr : fm_port.addr;
    assign accept   = mem_req && mem_gnt;

    assign fm_port.gnt = mem_gnt && fm_port.req && (win == SEL_FM);
    assign wt_port.gnt = mem_gnt && wt_port.req && (win == SEL_WT);

    assign fm_port.rvalid = mem_rvalid && (owner == SEL_FM);
    assign wt_port.rvalid = mem_rvalid && (owner == SEL_WT);
    assign fm_port.rdata  = mem_rdata;  // Data is shared, rvalid selects.
    assign wt_port.rdata  = mem_rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prio      <= SEL_FM;
            owner     <= SEL_FM;
            stall_q   <= 1'b0;
            stall_sel <= SEL_FM;
        end else begin
            stall_q   <= mem_req && !mem_gnt;
            stall_sel <= win;
            if (accept) begin
                prio  <= ~prio;
                owner <= win;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_rd_if.sv
/*
 * Read request bus between one loader and the memory arbiter.
 */

`default_nettype none

interface mem_rd_if import mem_port_pkg::*; ();

    logic      req;     // Level, held until gnt.
    mem_addr_t addr;
    logic      gnt;     // Read accepted this cycle.
    logic      rvalid;  // One cycle after gnt.
    mem_data_t rdata;

    modport requester (output req, output addr, input gnt, input rvalid, input rdata);

    modport arbiter (input req, input addr, output gnt, output rvalid, output rdata);

endinterface

`default_nettype wire

//--- verilog/nest3_counter.sv
/*
 * Three-level nested counter with clear and a completion pulse.
 */

`default_nettype none

module nest3_counter import tile_geom_pkg::*; #(
    parameter int n0_max = 4,
    parameter int n1_max = 4,
    parameter int n2_max = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   ena,
    input  logic   clean,
    output coord_t cnt0,
    output coord_t cnt1,
    output coord_t cnt2,
    output logic   done
);

    logic wrap0, wrap1, wrap2;

    assign wrap0 = ena && (cnt0 == coord_t'(n0_max - 1));
    assign wrap1 = wrap0 && (cnt1 == coord_t'(n1_max - 1));
    assign wrap2 = wrap1 && (cnt2 == coord_t'(n2_max - 1));
    assign done  = wrap2;    // All three roll over together.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt0 <= '0;
            cnt1 <= '0;
            cnt2 <= '0;
        end else if (clean) begin
            cnt0 <= '0;
            cnt1 <= '0;
            cnt2 <= '0;
        end else if (ena) begin
            cnt0 <= wrap0 ? '0 : cnt0 + 1'b1;
            if (wrap0) cnt1 <= wrap1 ? '0 : cnt1 + 1'b1;
            if (wrap1) cnt2 <= wrap2 ? '0 : cnt2 + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/tile_fifo.sv
/*
 * First-word-fall-through FIFO with a type-parameterized payload.
 */

`default_nettype none

`include "loader_defs.svh"

module tile_fifo #(
    parameter type payload_t = logic [31:0]
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  payload_t   push_data,
    input  logic       pop,
    output payload_t   head,
    output logic       empty,
    output logic [3:0] free_slots
);

    localparam int PW = $clog2(`FIFO_DEPTH);

    payload_t      mem [`FIFO_DEPTH];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [PW:0]   count;
    logic          do_push, do_pop;

    assign empty      = (count == '0);
    assign free_slots = 4'(`FIFO_DEPTH) - 4'(count);
    assign do_push    = push && (count != (PW+1)'(`FIFO_DEPTH));   // Full drops nothing here.
    assign do_pop     = pop && !empty;
    assign head       = mem[rd_ptr];    // Oldest entry.

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PW+1)'(do_push) - (PW+1)'(do_pop);
        end
    end

endmodule

`default_nettype wire

//--- verilog/tile_loader_top.sv
/*
 * Tile input stage top level. Two loaders share one memory read port
 * and each fills its own FIFO.
 */

`default_nettype none

module tile_loader_top import tile_geom_pkg::*, mem_port_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  coord_t       tile_base_m,
    input  coord_t       tile_base_row,
    input  coord_t       tile_base_col,
    input  mem_addr_t    weight_base,
    output logic         busy,
    output logic         mem_req,
    output mem_addr_t    mem_addr,
    input  logic         mem_gnt,
    input  logic         mem_rvalid,
    input  mem_data_t    mem_rdata,
    output fm_word_t     fm_data,
    output logic         fm_empty,
    input  logic         fm_pop,
    output weight_word_t w_data,
    output logic         w_empty,
    input  logic         w_pop
);

    logic         fm_busy, wt_busy;
    logic         fm_push, wt_push;
    fm_word_t     fm_push_data;
    weight_word_t wt_push_data;
    logic [3:0]   fm_free, wt_free;
    logic         start_idle;

    mem_rd_if fm_mem ();
    mem_rd_if wt_mem ();

    assign busy       = fm_busy || wt_busy;   // Both tiles must be in.
    assign start_idle = start && !busy;       // Ignored while either loader runs.

    in_fm_loader fm_loader (
        .clk          (clk),
        .rst          (rst),
        .start        (start_idle),
        .tile_base_m  (tile_base_m),
        .tile_base_row(tile_base_row),
        .tile_base_col(tile_base_col),
        .mem          (fm_mem),
        .free_slots   (fm_free),
        .push         (fm_push),
        .push_data    (fm_push_data),
        .busy         (fm_busy)
    );

    weight_loader wt_loader (
        .clk        (clk),
        .rst        (rst),
        .start      (start_idle),
        .weight_base(weight_base),
        .mem        (wt_mem),
        .free_slots (wt_free),
        .push       (wt_push),
        .push_data  (wt_push_data),
        .busy       (wt_busy)
    );

    mem_arbiter arb (
        .clk       (clk),
        .rst       (rst),
        .fm_port   (fm_mem),
        .wt_port   (wt_mem),
        .mem_req   (mem_req),
        .mem_gnt   (mem_gnt),
        .mem_addr  (mem_addr),
        .mem_rvalid(mem_rvalid),
        .mem_rdata (mem_rdata)
    );

    tile_fifo #(.payload_t(fm_word_t)) fm_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (fm_push),
        .push_data (fm_push_data),
        .pop       (fm_pop),
        .head      (fm_data),
        .empty     (fm_empty),
        .free_slots(fm_free)
    );

    tile_fifo #(.payload_t(weight_word_t)) wt_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (wt_push),
        .push_data (wt_push_data),
        .pop       (w_pop),
        .head      (w_data),
        .empty     (w_empty),
        .free_slots(wt_free)
    );

endmodule

`default_nettype wire

//--- verilog/tile_pkgs.sv
/*
 * Tile geometry and payload types, and the memory read bus types.
 */

`default_nettype none

`include "loader_defs.svh"

package tile_geom_pkg;

    // Tile or map coordinate.
    typedef logic [`CW-1:0] coord_t;

    // Feature-map element as stored in memory.
    typedef logic [`MEM_DW-1:0] fm_word_t;

    // Narrowed weight.
    typedef logic [`WT_DW-1:0] weight_word_t;

endpackage

package mem_port_pkg;

    // Word address.
    typedef logic [`MEM_AW-1:0] mem_addr_t;

    // Read data word.
    typedef logic [`MEM_DW-1:0] mem_data_t;

    // Requester select.
    typedef logic req_sel_t;

    localparam req_sel_t SEL_FM = 1'b0;
    localparam req_sel_t SEL_WT = 1'b1;

endpackage

`default_nettype wire

//--- verilog/weight_loader.sv
/*
 * Weight tile loader. Reads a flat block of words and keeps the low bits.
 */

`default_nettype none

`include "loader_defs.svh"

module weight_loader import tile_geom_pkg::*, mem_port_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  mem_addr_t    weight_base,
    mem_rd_if.requester  mem,
    input  logic [3:0]   free_slots,
    output logic         push,
    output weight_word_t push_data,
    output logic         busy
);

    mem_addr_t  base_q;
    logic       go;
    logic [5:0] issue_cnt;
    logic [5:0] push_cnt;
    logic [1:0] inflight;

    assign go = start && !busy;

    assign mem.addr = base_q + mem_addr_t'(issue_cnt);
    assign mem.req  = busy && (issue_cnt != 6'(`WT_WORDS)) &&
                      (free_slots > {2'b00, inflight});

    always_ff @(posedge clk) begin
        if (go) base_q <= weight_base;
        if (mem.rvalid) push_data <= mem.rdata[`WT_DW-1:0];  // Narrow to one weight.
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            push      <= 1'b0;
            issue_cnt <= '0;
            push_cnt  <= '0;
            inflight  <= '0;
        end else begin
            push     <= mem.rvalid;
            inflight <= inflight + {1'b0, mem.gnt} - {1'b0, push};
            if (go) begin
                busy      <= 1'b1;
                issue_cnt <= '0;
                push_cnt  <= '0;
            end else begin
                if (mem.gnt) issue_cnt <= issue_cnt + 1'b1;
                if (push) begin
                    push_cnt <= push_cnt + 1'b1;
                    if (push_cnt == 6'(`WT_WORDS - 1)) busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire
